// ==== corr_array.f ====
logic/corr_cfg_pkg.sv
logic/corr_bus_pkg.sv
logic/corr_bus_if.sv
logic/pair_correlator.sv
logic/visibility_readout.sv
logic/corr_array_top.sv
sim/corr_array_assertions.sv
sim/corr_array_tb.sv

// ==== logic/corr_array_top.sv ====
`default_nettype none

module corr_array_top (
   input  wire logic                             clk_i,
   input  wire logic                             rst,

   // Read bus
   input  wire logic                             cyc_i,
   input  wire logic                             stb_i,
   input  wire logic                             we_i,
   input  wire logic [corr_bus_pkg::ADR_W-1:0]   adr_i,
   output logic                                  ack_o,
   output logic [corr_cfg_pkg::ACCUM_W-1:0]      dat_o,

   // Antenna samples
   input  wire logic                             en_i,
   input  wire logic                             sw_i,
   input  wire logic [corr_cfg_pkg::NUM_ANT-1:0] re_i,
   input  wire logic [corr_cfg_pkg::NUM_ANT-1:0] im_i,

   output logic                                  overflow_o
);

   // ------------------------------
   // Links
   // ------------------------------
   corr_sample_if smp ();
   corr_bus_if    bus0 ();   // Readout to unit 0
   corr_bus_if    bus1 ();   // Readout to unit 1

   assign smp.en = en_i;
   assign smp.sw = sw_i;
   assign smp.re = re_i;
   assign smp.im = im_i;

   // ------------------------------
   // Correlator units and readout
   // ------------------------------
   pair_correlator #(.UNIT(0)) u_corr0 (
      .clk_i (clk_i),
      .rst   (rst),
      .smp   (smp),
      .bus   (bus0)
   );

   pair_correlator #(.UNIT(1)) u_corr1 (
      .clk_i (clk_i),
      .rst   (rst),
      .smp   (smp),
      .bus   (bus1)
   );

   visibility_readout u_readout (
      .clk_i      (clk_i),
      .rst        (rst),
      .cyc_i      (cyc_i),
      .stb_i      (stb_i),
      .we_i       (we_i),
      .adr_i      (adr_i),
      .ack_o      (ack_o),
      .dat_o      (dat_o),
      .overflow_o (overflow_o),
      .u0         (bus0),
      .u1         (bus1)
   );

endmodule

`default_nettype wire

// ==== logic/corr_bus_if.sv ====
`default_nettype none

// ------------------------------
// Readout to unit read link
// ------------------------------
interface corr_bus_if;
   logic                               stb;   // One-cycle read strobe
   logic [corr_bus_pkg::UNIT_ADR_W-1:0] adr;   // Pair and component
   logic [corr_cfg_pkg::ACCUM_W-1:0]   dat;   // Inactive bank word
   logic                               ack;   // One cycle after stb
   logic                               ovf;   // Sticky overflow of the unit

   modport host (output stb, output adr, input dat, input ack, input ovf);
   modport unit (input stb, input adr, output dat, output ack, output ovf);
endinterface

// ------------------------------
// Antenna samples, shared by all units
// ------------------------------
interface corr_sample_if;
   logic                             en;   // Sample valid
   logic                             sw;   // Bank switch pulse
   logic [corr_cfg_pkg::NUM_ANT-1:0] re;   // Sign bits, real part
   logic [corr_cfg_pkg::NUM_ANT-1:0] im;   // Sign bits, imaginary part

   modport src (output en, output sw, output re, output im);
   modport dst (input en, input sw, input re, input im);
endinterface

`default_nettype wire

// ==== logic/corr_bus_pkg.sv ====
`default_nettype none

package corr_bus_pkg;

   // ------------------------------
   // Bus address layout
   // ------------------------------
   localparam int ADR_W      = 4;
   localparam int UNIT_BIT   = 3;           // Selects the correlator unit
   localparam int PAIR_LSB   = 1;           // Pair field, bits 2..1
   localparam int PAIR_W     = 2;
   localparam int COMP_BIT   = 0;           // 0 for cosine, 1 for sine
   localparam int UNIT_ADR_W = ADR_W - 1;   // Address as seen by one unit

   // Read sequencer of the readout block
   typedef enum logic [1:0] {
      RD_IDLE,   // Ready for a new request
      RD_WAIT,   // Unit strobed, waiting on its ack
      RD_ACK     // ack_o high for one cycle
   } rd_state_e;

endpackage

`default_nettype wire

// ==== logic/corr_cfg_pkg.sv ====
`default_nettype none

package corr_cfg_pkg;

   // ------------------------------
   // Array sizes
   // ------------------------------
   localparam int NUM_ANT        = 8;   // Antennas, one re and one im sign bit each
   localparam int NUM_UNITS      = 2;   // Correlator units working side by side
   localparam int PAIRS_PER_UNIT = 4;   // Also the minimum sample spacing in cycles
   localparam int ACCUM_W        = 8;   // Visibility accumulator width
   localparam int ANT_IDX_W      = 3;
   localparam int PAIR_IDX_W     = $clog2(PAIRS_PER_UNIT);

   // ------------------------------
   // Antenna pairs per unit
   // ------------------------------
   // Index order is unit, pair, then antenna a (0) or b (1)
   localparam logic [ANT_IDX_W-1:0] PAIR_TABLE [NUM_UNITS][PAIRS_PER_UNIT][2] = '{
      '{'{3'd0, 3'd1}, '{3'd0, 3'd2}, '{3'd1, 3'd3}, '{3'd2, 3'd3}},   // Unit 0
      '{'{3'd4, 3'd5}, '{3'd4, 3'd6}, '{3'd5, 3'd7}, '{3'd6, 3'd7}}    // Unit 1
   };

   // Unit sequencer
   typedef enum logic {
      CS_IDLE,   // Waiting for a sample
      CS_RUN     // Stepping through the pairs
   } corr_state_e;

endpackage

`default_nettype wire

// ==== logic/pair_correlator.sv ====
`default_nettype none

module pair_correlator #(
   parameter int UNIT = 0   // Row of PAIR_TABLE handled by this unit
) (
   input wire logic   clk_i,
   input wire logic   rst,
   corr_sample_if.dst smp,
   corr_bus_if.unit   bus
);

   // Entries indexed by {bank, pair}
   logic [corr_cfg_pkg::ACCUM_W-1:0] cos_mem [2*corr_cfg_pkg::PAIRS_PER_UNIT];
   logic [corr_cfg_pkg::ACCUM_W-1:0] sin_mem [2*corr_cfg_pkg::PAIRS_PER_UNIT];

   corr_cfg_pkg::corr_state_e            state_q;
   logic [corr_cfg_pkg::PAIR_IDX_W-1:0]  pair_q;
   logic                                 bank_q;   // Active bank
   logic [corr_cfg_pkg::PAIRS_PER_UNIT-1:0] clr_q;  // Zero base on next update
   logic                                 ovf_q;
   logic                                 ack_q;
   logic [corr_cfg_pkg::ACCUM_W-1:0]     rd_dat_q;
   logic [corr_cfg_pkg::PAIR_IDX_W:0]    sweep_q = '0;   // Reset clear pointer
   logic [corr_cfg_pkg::NUM_ANT-1:0]     re_q, im_q;
   logic [corr_cfg_pkg::ANT_IDX_W-1:0]   ant_a, ant_b;
   logic [corr_cfg_pkg::PAIR_IDX_W:0]    wr_idx, rd_idx;
   logic [1:0]                           cos_inc, sin_inc;
   logic [corr_cfg_pkg::ACCUM_W-1:0]     cos_base, sin_base, cos_new, sin_new;
   logic [corr_cfg_pkg::ACCUM_W:0]       cos_sum, sin_sum;
   logic                                 sw_ok;

   // ------------------------------
   // Pair update datapath
   // ------------------------------
   assign ant_a  = corr_cfg_pkg::PAIR_TABLE[UNIT][pair_q][0];
   assign ant_b  = corr_cfg_pkg::PAIR_TABLE[UNIT][pair_q][1];
   assign wr_idx = {bank_q, pair_q};

   // Sign agreement counts, 0..2
   assign cos_inc = {1'b0, re_q[ant_a] ~^ re_q[ant_b]} + {1'b0, im_q[ant_a] ~^ im_q[ant_b]};
   assign sin_inc = {1'b0, im_q[ant_a] ~^ re_q[ant_b]} + {1'b0, re_q[ant_a] ~^ im_q[ant_b]};

   // First touch after a switch drops the old value
   assign cos_base = clr_q[pair_q] ? '0 : cos_mem[wr_idx];
   assign sin_base = clr_q[pair_q] ? '0 : sin_mem[wr_idx];

   assign cos_sum = {1'b0, cos_base} + {{(corr_cfg_pkg::ACCUM_W-1){1'b0}}, cos_inc};
   assign sin_sum = {1'b0, sin_base} + {{(corr_cfg_pkg::ACCUM_W-1){1'b0}}, sin_inc};

   // Saturate on carry out
   assign cos_new = cos_sum[corr_cfg_pkg::ACCUM_W] ? '1 : cos_sum[corr_cfg_pkg::ACCUM_W-1:0];
   assign sin_new = sin_sum[corr_cfg_pkg::ACCUM_W] ? '1 : sin_sum[corr_cfg_pkg::ACCUM_W-1:0];

   // Switch only between samples
   assign sw_ok = smp.sw && (state_q == corr_cfg_pkg::CS_IDLE);

   // ------------------------------
   // Sequencer and bank control
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         state_q <= corr_cfg_pkg::CS_IDLE;
         pair_q  <= '0;
         bank_q  <= 1'b0;
         clr_q   <= '1;   // Every entry starts from zero
         ovf_q   <= 1'b0;
      end else begin
         if (sw_ok) begin
            bank_q <= ~bank_q;
            clr_q  <= '1;
            ovf_q  <= 1'b0;
         end else if (state_q == corr_cfg_pkg::CS_RUN) begin
            clr_q[pair_q] <= 1'b0;
            if (cos_sum[corr_cfg_pkg::ACCUM_W] || sin_sum[corr_cfg_pkg::ACCUM_W])
               ovf_q <= 1'b1;   // Sticky until switch or reset
         end

         // A new sample may land on the last pair cycle
         if (smp.en) begin
            state_q <= corr_cfg_pkg::CS_RUN;
            pair_q  <= '0;
         end else if (state_q == corr_cfg_pkg::CS_RUN) begin
            pair_q <= pair_q + 1'b1;
            if (pair_q == corr_cfg_pkg::PAIR_IDX_W'(corr_cfg_pkg::PAIRS_PER_UNIT - 1))
               state_q <= corr_cfg_pkg::CS_IDLE;
         end
      end
   end

   // Held for the whole pair walk
   always_ff @(posedge clk_i) begin
      if (smp.en) begin
         re_q <= smp.re;
         im_q <= smp.im;
      end
   end

   // ------------------------------
   // Accumulator memories
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst)
         sweep_q <= sweep_q + 1'b1;   // One entry per reset cycle
      else
         sweep_q <= '0;
   end

   always_ff @(posedge clk_i) begin
      if (rst) begin
         cos_mem[sweep_q] <= '0;
         sin_mem[sweep_q] <= '0;
      end else if (state_q == corr_cfg_pkg::CS_RUN) begin
         cos_mem[wr_idx] <= cos_new;
         sin_mem[wr_idx] <= sin_new;
      end
   end

   // ------------------------------
   // Bus side, inactive bank only
   // ------------------------------
   assign rd_idx = {~bank_q, bus.adr[corr_bus_pkg::PAIR_LSB +: corr_bus_pkg::PAIR_W]};

   always_ff @(posedge clk_i) begin
      if (rst)
         ack_q <= 1'b0;
      else
         ack_q <= bus.stb;   // Fixed one-cycle latency
   end

   always_ff @(posedge clk_i) begin
      if (bus.stb)
         rd_dat_q <= bus.adr[corr_bus_pkg::COMP_BIT] ? sin_mem[rd_idx] : cos_mem[rd_idx];
   end

   assign bus.ack = ack_q;
   assign bus.dat = rd_dat_q;
   assign bus.ovf = ovf_q;

endmodule

`default_nettype wire

// ==== logic/visibility_readout.sv ====
`default_nettype none

module visibility_readout (
   input  wire logic                             clk_i,
   input  wire logic                             rst,
   input  wire logic                             cyc_i,
   input  wire logic                             stb_i,
   input  wire logic                             we_i,
   input  wire logic [corr_bus_pkg::ADR_W-1:0]   adr_i,
   output logic                                  ack_o,
   output logic [corr_cfg_pkg::ACCUM_W-1:0]      dat_o,
   output logic                                  overflow_o,
   corr_bus_if.host                              u0,
   corr_bus_if.host                              u1
);

   corr_bus_pkg::rd_state_e               state_q;
   logic                                  stb_q;    // Unit strobe, one cycle
   logic                                  unit_q;   // Addressed unit
   logic                                  wr_q;
   logic [corr_bus_pkg::UNIT_ADR_W-1:0]   adr_q;
   logic [corr_cfg_pkg::ACCUM_W-1:0]      dat_q;
   logic                                  req, sel_ack;
   logic [corr_cfg_pkg::ACCUM_W-1:0]      sel_dat;

   assign req     = cyc_i && stb_i;
   assign sel_ack = unit_q ? u1.ack : u0.ack;   // Response mux
   assign sel_dat = unit_q ? u1.dat : u0.dat;

   // ------------------------------
   // Read sequencer
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         state_q <= corr_bus_pkg::RD_IDLE;
         stb_q   <= 1'b0;
      end else begin
         stb_q <= 1'b0;
         case (state_q)
            corr_bus_pkg::RD_IDLE: if (req) begin
               state_q <= corr_bus_pkg::RD_WAIT;
               stb_q   <= 1'b1;
            end
            corr_bus_pkg::RD_WAIT: if (sel_ack) state_q <= corr_bus_pkg::RD_ACK;
            default:               state_q <= corr_bus_pkg::RD_IDLE;   // RD_ACK lasts one cycle
         endcase
      end
   end

   // Request fields and returned word
   always_ff @(posedge clk_i) begin
      if (state_q == corr_bus_pkg::RD_IDLE && req) begin
         unit_q <= adr_i[corr_bus_pkg::UNIT_BIT];
         adr_q  <= adr_i[corr_bus_pkg::UNIT_ADR_W-1:0];
         wr_q   <= we_i;
      end
      if (state_q == corr_bus_pkg::RD_WAIT && sel_ack)
         dat_q <= wr_q ? '0 : sel_dat;   // Writes return nothing useful
   end

   // Strobe goes only to the chosen unit
   assign u0.stb = stb_q && !unit_q;
   assign u1.stb = stb_q && unit_q;
   assign u0.adr = adr_q;
   assign u1.adr = adr_q;

   assign ack_o      = (state_q == corr_bus_pkg::RD_ACK);
   assign dat_o      = dat_q;
   assign overflow_o = u0.ovf | u1.ovf;   // Either unit saturated

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the corr_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module corr_array_tb \
   -Mdir "$BUILD_DIR" \
   -f corr_array.f
if [ $? -ne 0 ]; then
   echo "Verilator build did not succeed"
   exit 1
fi

"./$BUILD_DIR/Vcorr_array_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "test failed" "$LOG_FILE"; then
   exit 1
fi
exit 0

// ==== sim/corr_array_assertions.sv ====
`default_nettype none

module corr_array_assertions (
   input wire logic clk_i,
   input wire logic rst,
   input wire logic ack_i,   // Acknowledge pulse to watch
   input wire logic en_i,
   input wire logic sw_i,
   input wire logic run_i,   // Unit walking its pairs
   input wire logic ovf_i    // Sticky overflow flag
);
   timeunit 1ns;
   timeprecision 100ps;

   // Recent sample enables, newest in bit 0
   logic [corr_cfg_pkg::PAIRS_PER_UNIT-2:0] en_hist;

   always_ff @(posedge clk_i) begin
      if (rst)
         en_hist <= '0;
      else
         en_hist <= {en_hist[corr_cfg_pkg::PAIRS_PER_UNIT-3:0], en_i};
   end

   // ------------------------------
   // Bus and sample contracts
   // ------------------------------
   ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst) ack_i |=> !ack_i)
      else $error("Acknowledge held for more than one cycle");

   en_spacing: assert property (@(posedge clk_i) disable iff (rst) en_i |-> !(|en_hist))
      else $error("Sample enable repeated before the pair walk finished");

   sw_when_idle: assert property (@(posedge clk_i) disable iff (rst) sw_i |-> !run_i)
      else $error("Bank switch requested while a unit was running");

   ovf_sticky: assert property (@(posedge clk_i) disable iff (rst)
      $fell(ovf_i) |-> ($past(rst) || $past(sw_i)))
      else $error("Overflow flag dropped without reset or bank switch");

endmodule

// Unit side: sequencer, sample spacing, sticky overflow
bind pair_correlator corr_array_assertions u_unit_chk (
   .clk_i (clk_i),
   .rst   (rst),
   .ack_i (ack_q),
   .en_i  (smp.en),
   .sw_i  (smp.sw),
   .run_i (state_q == corr_cfg_pkg::CS_RUN),
   .ovf_i (ovf_q)
);

// Readout side: only the bus acknowledge
bind visibility_readout corr_array_assertions u_bus_chk (
   .clk_i (clk_i),
   .rst   (rst),
   .ack_i (ack_o),
   .en_i  (1'b0),
   .sw_i  (1'b0),
   .run_i (1'b0),
   .ovf_i (1'b0)
);

`default_nettype wire

// ==== sim/corr_array_tb.sv ====
`default_nettype none

module corr_array_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD = 40;
   localparam int SEED       = 9;
   localparam int NUM_ROWS   = 5;
   localparam int ACK_LIMIT  = 8;   // Cycles to wait for ack_o
   localparam int NUM_ADR    = 2 ** corr_bus_pkg::ADR_W;
   localparam int AW         = corr_cfg_pkg::ACCUM_W;
   localparam int NA         = corr_cfg_pkg::NUM_ANT;

   typedef struct packed {
      int unsigned n_smp;     // Samples in this row
      logic        rnd;       // Random pattern, else fixed re and im
      logic [7:0]  re;
      logic [7:0]  im;
      logic        sw;        // Switch banks before readback
      logic        rd_busy;   // Reads interleaved with samples
      logic        wr;        // Write cycles before readback
   } row_t;

   logic                             clk_i = 1'b0;
   logic                             rst;
   logic                             cyc_i, stb_i, we_i, ack_o;
   logic [corr_bus_pkg::ADR_W-1:0]   adr_i;
   logic [AW-1:0]                    dat_o;
   logic                             en_i, sw_i, overflow_o;
   logic [NA-1:0]                    re_i, im_i;

   row_t  rows  [NUM_ROWS];
   string names [NUM_ROWS];

   // Reference banks, [unit][bank][pair]
   logic [AW-1:0] m_cos [corr_cfg_pkg::NUM_UNITS][2][corr_cfg_pkg::PAIRS_PER_UNIT];
   logic [AW-1:0] m_sin [corr_cfg_pkg::NUM_UNITS][2][corr_cfg_pkg::PAIRS_PER_UNIT];
   logic          m_clr [corr_cfg_pkg::NUM_UNITS][corr_cfg_pkg::PAIRS_PER_UNIT];
   logic          m_bank, m_ovf;   // Active bank, OR of unit overflows
   int            checks = 0;
   int            errors = 0;

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   corr_array_top uut (
      .clk_i (clk_i), .rst (rst),
      .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i), .adr_i (adr_i),
      .ack_o (ack_o), .dat_o (dat_o),
      .en_i (en_i), .sw_i (sw_i), .re_i (re_i), .im_i (im_i),
      .overflow_o (overflow_o)
   );

   // ------------------------------
   // Reference model
   // ------------------------------
   task automatic model_switch(input logic clear_mem);
      for (int u = 0; u < corr_cfg_pkg::NUM_UNITS; u++) begin
         for (int p = 0; p < corr_cfg_pkg::PAIRS_PER_UNIT; p++) begin
            m_clr[u][p] = 1'b1;   // Zero base on next touch
            if (clear_mem) begin
               m_cos[u][0][p] = '0;
               m_cos[u][1][p] = '0;
               m_sin[u][0][p] = '0;
               m_sin[u][1][p] = '0;
            end
         end
      end
      m_bank = clear_mem ? 1'b0 : ~m_bank;
      m_ovf  = 1'b0;
   endtask

   task automatic model_sample(input logic [NA-1:0] re, input logic [NA-1:0] im);
      logic [corr_cfg_pkg::ANT_IDX_W-1:0] a, b;
      int c_sum, s_sum;
      for (int u = 0; u < corr_cfg_pkg::NUM_UNITS; u++) begin
         for (int p = 0; p < corr_cfg_pkg::PAIRS_PER_UNIT; p++) begin
            a = corr_cfg_pkg::PAIR_TABLE[u][p][0];
            b = corr_cfg_pkg::PAIR_TABLE[u][p][1];
            c_sum = m_clr[u][p] ? 0 : int'(m_cos[u][m_bank][p]);
            s_sum = m_clr[u][p] ? 0 : int'(m_sin[u][m_bank][p]);
            c_sum += int'(re[a] == re[b]) + int'(im[a] == im[b]);   // Cosine agreement
            s_sum += int'(im[a] == re[b]) + int'(re[a] == im[b]);   // Sine agreement
            if (c_sum > 255 || s_sum > 255)
               m_ovf = 1'b1;
            m_cos[u][m_bank][p] = (c_sum > 255) ? 8'd255 : 8'(c_sum);
            m_sin[u][m_bank][p] = (s_sum > 255) ? 8'd255 : 8'(s_sum);
            m_clr[u][p] = 1'b0;
         end
      end
   endtask

   // Inactive bank word at a bus address
   function automatic logic [AW-1:0] expect_word(input logic [corr_bus_pkg::ADR_W-1:0] adr);
      logic       u;
      logic [1:0] p;
      u = adr[corr_bus_pkg::UNIT_BIT];
      p = adr[corr_bus_pkg::PAIR_LSB +: corr_bus_pkg::PAIR_W];
      if (adr[corr_bus_pkg::COMP_BIT])
         return m_sin[u][~m_bank][p];
      return m_cos[u][~m_bank][p];
   endfunction

   // ------------------------------
   // Stimulus and checks
   // ------------------------------
   task automatic send_sample(input logic [NA-1:0] re, input logic [NA-1:0] im);
      @(negedge clk_i);
      en_i = 1'b1;
      re_i = re;
      im_i = im;
      model_sample(re, im);
      @(negedge clk_i);
      en_i = 1'b0;
      repeat (corr_cfg_pkg::PAIRS_PER_UNIT - 1) @(negedge clk_i);   // Keep sample spacing
   endtask

   task automatic switch_banks();
      @(negedge clk_i);
      sw_i = 1'b1;
      @(negedge clk_i);
      sw_i = 1'b0;
      model_switch(1'b0);
   endtask

   task automatic bus_cycle(input logic we, input logic [corr_bus_pkg::ADR_W-1:0] adr,
                            output logic [AW-1:0] dat, output logic acked);
      int waited;
      acked  = 1'b0;
      dat    = '0;
      waited = 0;
      @(negedge clk_i);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      while (!acked && waited < ACK_LIMIT) begin
         @(negedge clk_i);
         waited++;
         if (ack_o) begin
            acked = 1'b1;
            dat   = dat_o;   // Valid with ack_o
         end
      end
      cyc_i = 1'b0;   // Dropped in the cycle after ack_o
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic check_read(input logic [corr_bus_pkg::ADR_W-1:0] adr);
      logic [AW-1:0] dat, exp;
      logic          acked;
      exp = expect_word(adr);
      bus_cycle(1'b0, adr, dat, acked);
      checks++;
      assert (acked) else begin
         errors++;
         $display("Read of address %h at %0t ns got no acknowledge", adr, $time);
      end
      if (acked) begin
         checks++;
         assert (dat == exp) else begin
            errors++;
            $display("Mismatch at %0t ns: address %h read %0d, expected %0d",
                     $time, adr, dat, exp);
         end
      end
   endtask

   task automatic write_word(input logic [corr_bus_pkg::ADR_W-1:0] adr);
      logic [AW-1:0] dat;
      logic          acked;
      bus_cycle(1'b1, adr, dat, acked);   // Returned data is don't-care
      checks++;
      assert (acked) else begin
         errors++;
         $display("Write to address %h at %0t ns got no acknowledge", adr, $time);
      end
   endtask

   task automatic check_overflow();
      checks++;
      assert (overflow_o == m_ovf) else begin
         errors++;
         $display("Mismatch at %0t ns: overflow_o is %b, expected %b", $time, overflow_o, m_ovf);
      end
   endtask

   task automatic read_all();
      for (int a = 0; a < NUM_ADR; a++)
         check_read(4'(a));
   endtask

   function automatic int run_budget();
      int cycles;
      cycles = 200 + (NUM_ROWS + 1) * NUM_ADR * 8;   // Margin plus full readbacks
      for (int r = 0; r < NUM_ROWS; r++)
         cycles += int'(rows[r].n_smp) * 8;
      return cycles;
   endfunction

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      int            budget, err0, chk0;
      logic [NA-1:0] re, im;

      rst   = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      en_i  = 1'b0;
      sw_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      void'($urandom(SEED));

      rows[0] = '{20, 1'b1, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0};
      rows[1] = '{10, 1'b1, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0};
      rows[2] = '{12, 1'b1, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0};   // Lands on row 0's bank
      rows[3] = '{130, 1'b0, 8'hCF, 8'hAF, 1'b1, 1'b0, 1'b0};   // Only unit 0 saturates
      rows[4] = '{2, 1'b1, 8'h00, 8'h00, 1'b1, 1'b0, 1'b1};
      names[0] = "random samples then switch";
      names[1] = "reads during accumulation";
      names[2] = "second switch clears old data";
      names[3] = "saturation and overflow";
      names[4] = "write cycle ignored";

      budget = run_budget();
      fork
         begin
            #(budget * CLK_PERIOD);
            $display("Timeout: run did not finish within %0d cycles", budget);
            $display("test failed");
            $finish;
         end
      join_none

      model_switch(1'b1);
      repeat (10) @(negedge clk_i);
      rst = 1'b0;

      read_all();   // Swept memories read 0
      check_overflow();
      $display("Test 0 reset state: %0d checks, %0d errors", checks, errors);

      for (int r = 0; r < NUM_ROWS; r++) begin
         err0 = errors;
         chk0 = checks;
         for (int s = 0; s < int'(rows[r].n_smp); s++) begin
            re = rows[r].rnd ? 8'($urandom) : rows[r].re;
            im = rows[r].rnd ? 8'($urandom) : rows[r].im;
            if (rows[r].rd_busy) begin
               fork
                  send_sample(re, im);
                  check_read(4'(s % NUM_ADR));   // Inactive bank must not move
               join
            end else begin
               send_sample(re, im);
            end
         end
         @(negedge clk_i);   // Last pair written
         check_overflow();
         if (rows[r].sw) begin
            switch_banks();
            check_overflow();
         end
         if (rows[r].wr) begin
            write_word(4'h5);
            write_word(4'hA);
         end
         read_all();
         $display("Test %0d %s: %0d checks, %0d errors",
                  r + 1, names[r], checks - chk0, errors - err0);
      end

      $display("Summary: %0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire
